// File: mult_pkg.sv
`default_nettype none

package mult_pkg;

    // ------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------

    localparam int xlen       = 32;
    localparam int half_width = 16;
    localparam int num_pp     = 4;

    // ------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------

    // Operands and result
    typedef logic [xlen-1:0]        word_t;

    // One operand slice
    typedef logic [half_width-1:0]  half_t;

    // One 16x16 product
    typedef logic [xlen-1:0]        pp_t;

    // All partial products, pp0 in the low bits
    typedef logic [num_pp*xlen-1:0] pp_bus_t;

    // Unsigned full product
    typedef logic [2*xlen-1:0]      product_t;

    // RV32M multiply commands
    typedef enum logic [1:0] {
        mul_lo  = 2'd0,
        mul_h   = 2'd1,
        mul_hsu = 2'd2,
        mul_hu  = 2'd3
    } mult_cmd_e;

endpackage

`default_nettype wire

// File: mult_stage_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mult_stage_if #(
    parameter int width = 64
);

    logic [width-1:0] data;
    logic             high_word;
    logic             negate;
    logic             empty;
    logic             pop;

    // Stage holding the item
    modport producer (
        output data,
        output high_word,
        output negate,
        output empty,
        input  pop
    );

    // Stage taking the item
    modport consumer (
        input  data,
        input  high_word,
        input  negate,
        input  empty,
        output pop
    );

endinterface

`default_nettype wire

// File: mult_partial_products.sv
`timescale 1ns/1ps
`default_nettype none

module mult_partial_products (
    input  logic                clk,
    input  logic                rst_n,
    input  mult_pkg::word_t     op1,
    input  mult_pkg::word_t     op2,
    input  mult_pkg::mult_cmd_e cmd,
    input  logic                in_empty,
    output logic                in_pop,
    mult_stage_if.producer      x0x1
);

    import mult_pkg::*;

    logic    op1_signed;
    logic    op2_signed;
    logic    op1_neg;
    logic    op2_neg;
    word_t   mag1;
    word_t   mag2;
    half_t   a_lo;
    half_t   a_hi;
    half_t   b_lo;
    half_t   b_hi;
    pp_t     pp0;
    pp_t     pp1;
    pp_t     pp2;
    pp_t     pp3;
    pp_bus_t pp_bus;
    logic    take;

    logic    empty_q;
    pp_bus_t data_q;
    logic    high_word_q;
    logic    negate_q;

    // ------------------------------------------------------------
    // Operand conditioning
    // ------------------------------------------------------------

    // MUL low word is the same either way, so treat it unsigned
    assign op1_signed = (cmd == mul_h) || (cmd == mul_hsu);
    assign op2_signed = (cmd == mul_h);

    assign op1_neg = op1_signed && op1[xlen-1];
    assign op2_neg = op2_signed && op2[xlen-1];

    assign mag1 = op1_neg ? -op1 : op1;
    assign mag2 = op2_neg ? -op2 : op2;

    assign a_lo = mag1[half_width-1:0];
    assign a_hi = mag1[xlen-1:half_width];
    assign b_lo = mag2[half_width-1:0];
    assign b_hi = mag2[xlen-1:half_width];

    // Weights 0, 16, 16, 32
    assign pp0 = pp_t'(a_lo) * pp_t'(b_lo);
    assign pp1 = pp_t'(a_lo) * pp_t'(b_hi);
    assign pp2 = pp_t'(a_hi) * pp_t'(b_lo);
    assign pp3 = pp_t'(a_hi) * pp_t'(b_hi);

    assign pp_bus = {pp3, pp2, pp1, pp0};

    // ------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------

    assign take   = !in_empty && (empty_q || x0x1.pop);
    assign in_pop = take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            empty_q <= 1'b1;
        end else if (take) begin
            empty_q <= 1'b0;
        end else if (x0x1.pop) begin
            empty_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q      <= pp_bus;
            high_word_q <= (cmd != mul_lo);
            negate_q    <= op1_neg ^ op2_neg;
        end
    end

    assign x0x1.data      = data_q;
    assign x0x1.high_word = high_word_q;
    assign x0x1.negate    = negate_q;
    assign x0x1.empty     = empty_q;

endmodule

`default_nettype wire

// File: mult_accumulate.sv
`timescale 1ns/1ps
`default_nettype none

module mult_accumulate (
    input  logic           clk,
    input  logic           rst_n,
    mult_stage_if.consumer x0x1,
    mult_stage_if.producer x1x2
);

    import mult_pkg::*;

    product_t sum;
    logic     take;

    logic     empty_q;
    product_t data_q;
    logic     high_word_q;
    logic     negate_q;

    // Slice i pairs a half (i >> 1) with b half (i & 1)
    always_comb begin
        pp_t pp_slice;
        sum = '0;
        for (int i = 0; i < num_pp; i++) begin
            pp_slice = x0x1.data[i*xlen +: xlen];
            sum      = sum + (product_t'(pp_slice) << (((i & 1) + (i >> 1)) * half_width));
        end
    end

    // ------------------------------------------------------------
    // Stage register
    // ------------------------------------------------------------

    assign take      = !x0x1.empty && (empty_q || x1x2.pop);
    assign x0x1.pop  = take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            empty_q <= 1'b1;
        end else if (take) begin
            empty_q <= 1'b0;
        end else if (x1x2.pop) begin
            empty_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            data_q      <= sum;
            high_word_q <= x0x1.high_word;
            negate_q    <= x0x1.negate;
        end
    end

    assign x1x2.data      = data_q;
    assign x1x2.high_word = high_word_q;
    assign x1x2.negate    = negate_q;
    assign x1x2.empty     = empty_q;

endmodule

`default_nettype wire

// File: mult_result_select.sv
`timescale 1ns/1ps
`default_nettype none

module mult_result_select (
    input  logic            clk,
    input  logic            rst_n,
    mult_stage_if.consumer  x1x2,
    input  logic            out_pop,
    output logic            out_empty,
    output mult_pkg::word_t result
);

    import mult_pkg::*;

    product_t prod_signed;
    word_t    word_sel;
    logic     take;

    logic     empty_q;
    word_t    result_q;

    // ------------------------------------------------------------
    // Sign and word select
    // ------------------------------------------------------------

    // Two's complement restores the sign of the magnitude product
    assign prod_signed = x1x2.negate ? -x1x2.data : x1x2.data;

    assign word_sel = x1x2.high_word ? prod_signed[2*xlen-1:xlen]
                                     : prod_signed[xlen-1:0];

    // ------------------------------------------------------------
    // Output register
    // ------------------------------------------------------------

    assign take     = !x1x2.empty && (empty_q || out_pop);
    assign x1x2.pop = take;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            empty_q <= 1'b1;
        end else if (take) begin
            empty_q <= 1'b0;
        end else if (out_pop) begin
            empty_q <= 1'b1;
        end
    end

    // Held until the consumer pops
    always_ff @(posedge clk) begin
        if (take) begin
            result_q <= word_sel;
        end
    end

    assign out_empty = empty_q;
    assign result    = result_q;

endmodule

`default_nettype wire

// File: mult_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mult_pipeline (
    input  logic                clk,
    input  logic                rst_n,

    // Operation queue
    input  mult_pkg::word_t     op1,
    input  mult_pkg::word_t     op2,
    input  mult_pkg::mult_cmd_e cmd,
    input  logic                in_empty,
    output logic                in_pop,

    // Result queue
    input  logic                out_pop,
    output logic                out_empty,
    output mult_pkg::word_t     result
);

    import mult_pkg::*;

    // ------------------------------------------------------------
    // Stage links
    // ------------------------------------------------------------

    mult_stage_if #(
        .width ($bits(pp_bus_t))
    ) x0x1 ();

    mult_stage_if #(
        .width ($bits(product_t))
    ) x1x2 ();

    // ------------------------------------------------------------
    // Stages
    // ------------------------------------------------------------

    // x0
    mult_partial_products x0_stage (
        .clk      (clk),
        .rst_n    (rst_n),
        .op1      (op1),
        .op2      (op2),
        .cmd      (cmd),
        .in_empty (in_empty),
        .in_pop   (in_pop),
        .x0x1     (x0x1.producer)
    );

    // x1
    mult_accumulate x1_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .x0x1  (x0x1.consumer),
        .x1x2  (x1x2.producer)
    );

    // x2
    mult_result_select x2_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .x1x2      (x1x2.consumer),
        .out_pop   (out_pop),
        .out_empty (out_empty),
        .result    (result)
    );

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
    end

    always #(half_period) clk = ~clk;

    // Reset held over the first three rising edges
    initial begin
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_mult.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mult;

    import mult_pkg::*;

    localparam int seed_init      = 32'hb4da;
    localparam int timeout_cycles = 2000;
    localparam int num_mul_random = 50;
    localparam int num_h_random   = 30;
    localparam int num_stream     = 100;
    localparam int pipe_depth     = 3;

    logic      clk;
    logic      rst_n;
    word_t     op1;
    word_t     op2;
    mult_cmd_e cmd;
    logic      in_empty;
    logic      in_pop;
    logic      out_pop;
    logic      out_empty;
    word_t     result;

    int        seed = seed_init;
    int        cycle_count = 0;
    int        take_count = 0;
    int        result_count = 0;
    int        issue_waits;
    word_t     exp_q[$];

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mult_pipeline UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .op1       (op1),
        .op2       (op2),
        .cmd       (cmd),
        .in_empty  (in_empty),
        .in_pop    (in_pop),
        .out_pop   (out_pop),
        .out_empty (out_empty),
        .result    (result)
    );

    // ------------------------------------------------------------
    // Reference model and helpers
    // ------------------------------------------------------------

    // Full 64-bit product with the RV32M signedness of each command
    function automatic word_t ref_multiply(input word_t a, input word_t b, input mult_cmd_e c);
        logic signed [2*xlen-1:0] ea;
        logic signed [2*xlen-1:0] eb;
        logic [2*xlen-1:0]        prod;
        ea = (c == mul_h || c == mul_hsu) ? {{xlen{a[xlen-1]}}, a} : {{xlen{1'b0}}, a};
        eb = (c == mul_h) ? {{xlen{b[xlen-1]}}, b} : {{xlen{1'b0}}, b};
        prod = ea * eb;
        return (c == mul_lo) ? prod[xlen-1:0] : prod[2*xlen-1:xlen];
    endfunction

    task automatic stop_run(input string why);
        $display("Some tests failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
            stop_run("value mismatch");
        end
    endtask

    // Presents one operation and returns after the edge that takes it
    task automatic issue(input word_t a, input word_t b, input mult_cmd_e c);
        op1      <= a;
        op2      <= b;
        cmd      <= c;
        in_empty <= 1'b0;
        issue_waits = 0;
        do begin
            @(negedge clk);
            issue_waits++;
        end while (!in_pop);
        @(posedge clk);
    endtask

    task automatic issue_random(input mult_cmd_e c);
        word_t a;
        word_t b;
        a = $random(seed);
        b = $random(seed);
        issue(a, b, c);
    endtask

    // Pipeline latency plus one idle cycle
    task automatic drain();
        in_empty <= 1'b1;
        repeat (pipe_depth + 1) @(posedge clk);
        check_value("results returned", 64'(take_count), 64'(result_count));
    endtask

    // ------------------------------------------------------------
    // Take and result monitor
    // ------------------------------------------------------------

    always @(negedge clk) begin : monitor
        word_t expected;
        if (rst_n) begin
            if (in_pop) begin
                exp_q.push_back(ref_multiply(op1, op2, cmd));
                take_count++;
            end
            if (!out_empty && out_pop) begin
                if (exp_q.size() == 0) begin
                    $display("A result came out at %0t with no operation pending", $time);
                    stop_run("unexpected result");
                end
                expected = exp_q.pop_front();
                check_value("result", 64'(expected), 64'(result));
                result_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            stop_run("timeout");
        end
    end

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------

    task automatic reset_state();
        int k;
        for (k = 0; k < 5; k++) begin
            @(negedge clk);
            check_value("out_empty", 64'd1, 64'(out_empty));
            check_value("in_pop", 64'd0, 64'(in_pop));
        end
        @(posedge clk);
    endtask

    task automatic mul_low_word();
        int n;
        int k;
        out_pop <= 1'b1;
        issue(32'd6, 32'd7, mul_lo);
        in_empty <= 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (out_empty);
        check_value("latency", 64'(pipe_depth), 64'(n));
        @(posedge clk);
        drain();
        issue(32'd0, 32'd12345, mul_lo);
        issue(32'd1, 32'hdead_beef, mul_lo);
        issue(32'hffff_ffff, 32'hffff_ffff, mul_lo);
        issue(32'h8000_0000, 32'h8000_0000, mul_lo);
        for (k = 0; k < num_mul_random; k++) begin
            issue_random(mul_lo);
        end
        drain();
    endtask

    task automatic mulh_signed();
        int k;
        out_pop <= 1'b1;
        issue(32'hffff_ffff, 32'hffff_ffff, mul_h);
        issue(32'h8000_0000, 32'h8000_0000, mul_h);
        issue(32'h7fff_0001, 32'hffff_fffd, mul_h);
        for (k = 0; k < num_h_random; k++) begin
            issue_random(mul_h);
        end
        drain();
    endtask

    task automatic mulhsu_mulhu();
        int k;
        out_pop <= 1'b1;
        issue(32'hffff_ffff, 32'hffff_ffff, mul_hsu);
        issue(32'hffff_ffff, 32'hffff_ffff, mul_hu);
        issue(32'h8000_0000, 32'hffff_ffff, mul_hsu);
        issue(32'h8000_0000, 32'hffff_ffff, mul_hu);
        for (k = 0; k < num_h_random; k++) begin
            issue_random(mul_hsu);
            issue_random(mul_hu);
        end
        drain();
    endtask

    task automatic backpressure_order();
        int    k;
        word_t held;
        out_pop <= 1'b0;
        issue(32'h1234_5678, 32'h9abc_def0, mul_lo);
        issue(32'hffff_fff0, 32'h0000_0010, mul_h);
        issue(32'h8000_0001, 32'hffff_ffff, mul_hsu);
        op1 <= 32'h0bad_cafe;
        op2 <= 32'h1357_9bdf;
        cmd <= mul_hu;
        held = '0;
        for (k = 0; k < 6; k++) begin
            @(negedge clk);
            if (k == 0) begin
                held = result;
            end
            check_value("in_pop", 64'd0, 64'(in_pop));
            check_value("out_empty", 64'd0, 64'(out_empty));
            check_value("result", 64'(held), 64'(result));
        end
        @(posedge clk);
        out_pop <= 1'b1;
        do begin
            @(negedge clk);
        end while (!in_pop);
        @(posedge clk);
        drain();
    endtask

    task automatic streaming();
        int        k;
        word_t     r;
        mult_cmd_e c;
        out_pop <= 1'b1;
        for (k = 0; k < num_stream; k++) begin
            r = $random(seed);
            c = mult_cmd_e'(r[1:0]);
            issue_random(c);
            if (k > 0) begin
                check_value("cycles per take", 64'd1, 64'(issue_waits));
            end
        end
        drain();
    endtask

    // ------------------------------------------------------------
    // Sequence
    // ------------------------------------------------------------

    initial begin
        op1      <= '0;
        op2      <= '0;
        cmd      <= mul_lo;
        in_empty <= 1'b1;
        out_pop  <= 1'b0;
        reset_state();
        mul_low_word();
        mulh_signed();
        mulhsu_mulhu();
        backpressure_order();
        streaming();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
mult_pkg.sv
mult_stage_if.sv
mult_partial_products.sv
mult_accumulate.sv
mult_result_select.sv
mult_pipeline.sv
tb_clock_gen.sv
tb_mult.sv

// File: Makefile
RTL_FILES = mult_pkg.sv mult_stage_if.sv mult_partial_products.sv \
            mult_accumulate.sv mult_result_select.sv mult_pipeline.sv

.PHONY: all sim lint clean

all: sim

sim:
	verilator --binary -j 0 --top-module tb_mult -f tb.f -o sim_tb
	./obj_dir/sim_tb

lint:
	verilator --lint-only --top-module mult_pipeline $(RTL_FILES)

clean:
	rm -rf obj_dir
